// File: isaPkg.sv
package isaPkg;

    // Instruction fields as they come out of the instruction register
    typedef logic [6:0] opcodeT;
    typedef logic [2:0] funct3T;
    typedef logic [6:0] funct7T;

    // Major opcodes handled by the sequencer
    parameter opcodeT opBranch = 7'b1100011;
    parameter opcodeT opJal    = 7'b1101111;
    parameter opcodeT opJalr   = 7'b1100111;
    parameter opcodeT opAuipc  = 7'b0010111;
    parameter opcodeT opImm    = 7'b0010011;
    parameter opcodeT opLoad   = 7'b0000011;
    parameter opcodeT opStore  = 7'b0100011;
    parameter opcodeT opReg    = 7'b0110011;

    // Branch condition in funct3
    parameter funct3T f3Beq = 3'b000;
    parameter funct3T f3Bne = 3'b001;

    // ALU operation in funct3
    // Sub sits on its own code in this core, not on funct7
    parameter funct3T f3Add  = 3'b000;
    parameter funct3T f3Sub  = 3'b100;
    parameter funct3T f3And  = 3'b111;
    parameter funct3T f3Or   = 3'b110;
    parameter funct3T f3Sll  = 3'b001;
    parameter funct3T f3Srl  = 3'b101;
    parameter funct3T f3Slt  = 3'b010;
    parameter funct3T f3Sltu = 3'b011;

    // Alternate operation on the add slot, R-type only
    parameter funct7T f7Alt = 7'b0000001;

    // Operation code seen by the ALU
    typedef enum logic [2:0] {
        aluAnd = 3'b000,
        aluOr  = 3'b001,
        aluAdd = 3'b010,
        aluSrl = 3'b011,
        aluSlt = 3'b100,
        aluAlt = 3'b101,
        aluSub = 3'b110,
        aluSll = 3'b111
    } aluCtrlT;

endpackage

// File: ctrlPkg.sv
package ctrlPkg;

    // Sequencer states, one per datapath step
    typedef enum logic [4:0] {
        sFetch        = 5'd0,
        sDecode       = 5'd1,
        sBeq          = 5'd2,
        sBne          = 5'd3,
        sJalWriteReg  = 5'd4,
        // Shared by JAL and JALR
        sJumpPc       = 5'd5,
        sJalrWriteReg = 5'd6,
        sAuipcExec    = 5'd7,
        sAuipcWb      = 5'd8,
        sImmExec      = 5'd9,
        // Shared by I-type and R-type
        sAluWb        = 5'd10,
        sLoadAdr      = 5'd11,
        sLoadRead     = 5'd12,
        sLoadWb       = 5'd13,
        sStoreAdr     = 5'd14,
        sStoreWrite   = 5'd15,
        sRegExec      = 5'd16
    } stateT;

    // Operation request from the sequencer to the ALU decoder
    typedef enum logic [1:0] {
        aluOpAdd   = 2'b00,
        aluOpSub   = 2'b01,
        aluOpFunct = 2'b10
    } aluOpT;

    // Register file write data select
    typedef enum logic [1:0] {
        selAluOut  = 2'b00,
        selMemData = 2'b01,
        selPc      = 2'b10
    } memToRegT;

    // ALU operand B select
    // Code 10 is not wired in the datapath
    typedef enum logic [1:0] {
        srcBReg  = 2'b00,
        srcBFour = 2'b01,
        srcBImm  = 2'b11
    } srcBT;

    // Immediate generator format
    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immJ = 3'b100,
        immU = 3'b101
    } immSelT;

endpackage

// File: controlFsm.sv
`timescale 1ns/1ps

module controlFsm (
    input  logic              clk,
    input  logic              rst,
    input  isaPkg::opcodeT    opCode_i,
    input  isaPkg::funct3T    funct3_i,
    // Datapath mux selects
    output ctrlPkg::memToRegT memToReg_o,
    output logic              regDst_o,
    output logic              iOrD_o,
    output logic              pcSrc_o,
    output ctrlPkg::srcBT     aluSrcB_o,
    output logic              aluSrcA_o,
    // Write enables
    output logic              irWrite_o,
    output logic              memWrite_o,
    output logic              pcWrite_o,
    output logic              regWrite_o,
    // Branch condition flags
    output logic              branchEq_o,
    output logic              branchNe_o,
    output ctrlPkg::immSelT   immSel_o,
    // Request to the ALU decoder
    output ctrlPkg::aluOpT    aluOp_o
);

    import isaPkg::*;
    import ctrlPkg::*;

    stateT state;
    stateT stateNext;

    // State register
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= sFetch;
        end
        else
        begin
            state <= stateNext;
        end
    end

    // Next state
    always_comb
    begin
        case (state)
            sFetch:
                stateNext = sDecode;
            sDecode:
            begin
                // Branch on opcode, branches also look at funct3
                case (opCode_i)
                    opBranch:
                    begin
                        if (funct3_i == f3Beq)
                            stateNext = sBeq;
                        else if (funct3_i == f3Bne)
                            stateNext = sBne;
                        else
                            stateNext = sFetch;
                    end
                    opJal:   stateNext = sJalWriteReg;
                    opJalr:  stateNext = sJalrWriteReg;
                    opAuipc: stateNext = sAuipcExec;
                    opImm:   stateNext = sImmExec;
                    opLoad:  stateNext = sLoadAdr;
                    opStore: stateNext = sStoreAdr;
                    opReg:   stateNext = sRegExec;
                    // Unknown opcode parks here until reset
                    default: stateNext = sDecode;
                endcase
            end
            sJalWriteReg, sJalrWriteReg:
                stateNext = sJumpPc;
            sAuipcExec:
                stateNext = sAuipcWb;
            sImmExec, sRegExec:
                stateNext = sAluWb;
            sLoadAdr:
                stateNext = sLoadRead;
            sLoadRead:
                stateNext = sLoadWb;
            sStoreAdr:
                stateNext = sStoreWrite;
            // Last step of every chain, plus unused encodings
            default:
                stateNext = sFetch;
        endcase
    end

    // Control table, Moore outputs only
    always_comb
    begin
        // Idle values, each state overrides what it needs
        memToReg_o = selAluOut;
        regDst_o   = 1'b0;
        iOrD_o     = 1'b0;
        pcSrc_o    = 1'b0;
        aluSrcB_o  = srcBReg;
        aluSrcA_o  = 1'b0;
        irWrite_o  = 1'b0;
        memWrite_o = 1'b0;
        pcWrite_o  = 1'b0;
        regWrite_o = 1'b0;
        branchEq_o = 1'b0;
        branchNe_o = 1'b0;
        immSel_o   = immI;
        aluOp_o    = aluOpAdd;
        case (state)
            sFetch:
            begin
                // PC + 4 and latch the instruction
                aluSrcB_o = srcBFour;
                irWrite_o = 1'b1;
                pcWrite_o = 1'b1;
            end
            sDecode:
            begin
                // Precompute branch target in ALUOut
                aluSrcB_o = srcBImm;
                immSel_o  = immB;
            end
            sBeq, sBne:
            begin
                // rs1 - rs2, PC takes target on condition
                pcSrc_o    = 1'b1;
                aluSrcA_o  = 1'b1;
                aluOp_o    = aluOpSub;
                branchEq_o = (state == sBeq);
                branchNe_o = (state == sBne);
                immSel_o   = immB;
            end
            sJalWriteReg:
            begin
                // rd gets PC while ALU forms PC + imm
                memToReg_o = selPc;
                regDst_o   = 1'b1;
                aluSrcB_o  = srcBImm;
                regWrite_o = 1'b1;
                immSel_o   = immJ;
            end
            sJalrWriteReg:
            begin
                // Same as JAL but the base is rs1
                memToReg_o = selPc;
                regDst_o   = 1'b1;
                aluSrcA_o  = 1'b1;
                aluSrcB_o  = srcBImm;
                regWrite_o = 1'b1;
            end
            sJumpPc:
            begin
                // Load jump target from ALUOut
                pcSrc_o   = 1'b1;
                aluSrcB_o = srcBFour;
                pcWrite_o = 1'b1;
                immSel_o  = immJ;
            end
            sAuipcExec:
            begin
                aluSrcB_o = srcBImm;
                immSel_o  = immU;
            end
            sAuipcWb:
            begin
                regDst_o   = 1'b1;
                aluSrcA_o  = 1'b1;
                regWrite_o = 1'b1;
                immSel_o   = immU;
            end
            sImmExec:
            begin
                aluSrcA_o = 1'b1;
                aluSrcB_o = srcBImm;
                aluOp_o   = aluOpFunct;
            end
            sRegExec:
            begin
                aluSrcA_o = 1'b1;
                aluOp_o   = aluOpFunct;
            end
            sAluWb:
            begin
                regDst_o   = 1'b1;
                aluSrcA_o  = 1'b1;
                aluSrcB_o  = srcBImm;
                regWrite_o = 1'b1;
                aluOp_o    = aluOpFunct;
            end
            sLoadAdr:
            begin
                // rs1 + offset
                aluSrcA_o = 1'b1;
                aluSrcB_o = srcBImm;
            end
            sLoadRead:
            begin
                // Memory addressed by ALUOut
                iOrD_o    = 1'b1;
                aluSrcA_o = 1'b1;
                aluSrcB_o = srcBImm;
            end
            sLoadWb:
            begin
                memToReg_o = selMemData;
                regDst_o   = 1'b1;
                iOrD_o     = 1'b1;
                aluSrcA_o  = 1'b1;
                aluSrcB_o  = srcBImm;
                regWrite_o = 1'b1;
            end
            sStoreAdr:
            begin
                aluSrcA_o = 1'b1;
                aluSrcB_o = srcBImm;
                immSel_o  = immS;
            end
            sStoreWrite:
            begin
                // rs2 goes to memory at ALUOut
                iOrD_o     = 1'b1;
                aluSrcA_o  = 1'b1;
                aluSrcB_o  = srcBImm;
                memWrite_o = 1'b1;
                immSel_o   = immS;
            end
            default:
            begin
                // Unused encodings keep the idle values
            end
        endcase
    end

endmodule

// File: aluDecoder.sv
`timescale 1ns/1ps

module aluDecoder (
    input  logic            clk,
    input  logic            rst,
    input  isaPkg::opcodeT  opCode_i,
    input  isaPkg::funct3T  funct3_i,
    input  isaPkg::funct7T  funct7_i,
    // Operation request from the sequencer
    input  ctrlPkg::aluOpT  aluOp_i,
    output isaPkg::aluCtrlT aluControl_o
);

    import isaPkg::*;
    import ctrlPkg::*;

    aluCtrlT functDecode;
    aluCtrlT functReg;

    // Decode of the current funct fields
    always_comb
    begin
        case (funct3_i)
            f3Add:
            begin
                // Alternate op only for register-register form
                if ((opCode_i == opReg) && (funct7_i == f7Alt))
                    functDecode = aluAlt;
                else
                    functDecode = aluAdd;
            end
            f3Sub:
                functDecode = aluSub;
            f3And:
                functDecode = aluAnd;
            f3Or:
                functDecode = aluOr;
            f3Sll:
                functDecode = aluSll;
            f3Srl:
                functDecode = aluSrl;
            // Signed and unsigned compare share one ALU code
            f3Slt, f3Sltu:
                functDecode = aluSlt;
            default:
                functDecode = aluAdd;
        endcase
    end

    // Sampled every edge, fields are stable well before execute
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            functReg <= aluAnd;
        end
        else
        begin
            functReg <= functDecode;
        end
    end

    // Fixed add or subtract, else the registered funct decode
    always_comb
    begin
        case (aluOp_i)
            aluOpAdd:   aluControl_o = aluAdd;
            aluOpSub:   aluControl_o = aluSub;
            aluOpFunct: aluControl_o = functReg;
            default:    aluControl_o = aluAdd;
        endcase
    end

endmodule

// File: multicycleControl.sv
`timescale 1ns/1ps

module multicycleControl (
    input  logic              clk,
    input  logic              rst,
    // Fields of the current instruction, held for the whole instruction
    input  isaPkg::opcodeT    opCode_i,
    input  isaPkg::funct3T    funct3_i,
    input  isaPkg::funct7T    funct7_i,
    // Datapath mux selects
    output ctrlPkg::memToRegT memToReg_o,
    output logic              regDst_o,
    output logic              iOrD_o,
    output logic              pcSrc_o,
    output ctrlPkg::srcBT     aluSrcB_o,
    output logic              aluSrcA_o,
    // Write enables
    output logic              irWrite_o,
    output logic              memWrite_o,
    output logic              pcWrite_o,
    output logic              regWrite_o,
    // Branch flags and immediate format
    output logic              branchEq_o,
    output logic              branchNe_o,
    output ctrlPkg::immSelT   immSel_o,
    // ALU operation
    output isaPkg::aluCtrlT   aluControl_o
);

    import ctrlPkg::*;

    // Sequencer to ALU decoder request
    aluOpT aluOp;

    // State sequencer and control table
    controlFsm i_controlFsm (
        .clk        (clk),
        .rst        (rst),
        .opCode_i   (opCode_i),
        .funct3_i   (funct3_i),
        .memToReg_o (memToReg_o),
        .regDst_o   (regDst_o),
        .iOrD_o     (iOrD_o),
        .pcSrc_o    (pcSrc_o),
        .aluSrcB_o  (aluSrcB_o),
        .aluSrcA_o  (aluSrcA_o),
        .irWrite_o  (irWrite_o),
        .memWrite_o (memWrite_o),
        .pcWrite_o  (pcWrite_o),
        .regWrite_o (regWrite_o),
        .branchEq_o (branchEq_o),
        .branchNe_o (branchNe_o),
        .immSel_o   (immSel_o),
        .aluOp_o    (aluOp)
    );

    // Funct decode and ALU code select
    aluDecoder i_aluDecoder (
        .clk          (clk),
        .rst          (rst),
        .opCode_i     (opCode_i),
        .funct3_i     (funct3_i),
        .funct7_i     (funct7_i),
        .aluOp_i      (aluOp),
        .aluControl_o (aluControl_o)
    );

endmodule

// File: tbChecks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Mux selects, one-bit selects packed as {regDst, iOrD, pcSrc, aluSrcA}
task automatic compareSelects(
    input string      stateName,
    input memToRegT   gotMemToReg,
    input memToRegT   wantMemToReg,
    input srcBT       gotSrcB,
    input srcBT       wantSrcB,
    input logic [3:0] gotSel,
    input logic [3:0] wantSel
);
    if (gotMemToReg !== wantMemToReg)
    begin
        $display("error at time %0d ns: %s memToReg got %b expected %b",
                 $time, stateName, gotMemToReg, wantMemToReg);
        stopOnError();
    end
    if (gotSrcB !== wantSrcB)
    begin
        $display("error at time %0d ns: %s aluSrcB got %b expected %b",
                 $time, stateName, gotSrcB, wantSrcB);
        stopOnError();
    end
    if (gotSel !== wantSel)
    begin
        $display("error at time %0d ns: %s {regDst,iOrD,pcSrc,aluSrcA} got %b expected %b",
                 $time, stateName, gotSel, wantSel);
        stopOnError();
    end
endtask

// Enables and branch flags as {irWrite, memWrite, pcWrite, regWrite, branchEq, branchNe}
task automatic compareEnables(
    input string      stateName,
    input logic [5:0] gotEn,
    input logic [5:0] wantEn
);
    if (gotEn !== wantEn)
    begin
        $display("error at time %0d ns: %s enables got %b expected %b",
                 $time, stateName, gotEn, wantEn);
        stopOnError();
    end
endtask

// Immediate generator format
task automatic compareImmSel(input string stateName, input immSelT got, input immSelT want);
    if (got !== want)
    begin
        $display("error at time %0d ns: %s immSel got %b expected %b",
                 $time, stateName, got, want);
        stopOnError();
    end
endtask

// ALU operation code
task automatic compareAluCtrl(input string stateName, input aluCtrlT got, input aluCtrlT want);
    if (got !== want)
    begin
        $display("error at time %0d ns: %s aluControl got %b expected %b",
                 $time, stateName, got, want);
        stopOnError();
    end
endtask

`endif

// File: tbMulticycleControl.sv
`timescale 1ns/1ps

module tbMulticycleControl;

    import isaPkg::*;
    import ctrlPkg::*;

    localparam int clkPeriodNs = 100;
    localparam int resetCycles = 8;
    localparam int stimDepth   = 64;
    // Budget per instruction for the watchdog
    localparam int cyclesPerVector = 10;

    logic     clk;
    logic     rst;
    opcodeT   opCode;
    funct3T   funct3;
    funct7T   funct7;

    // DUT outputs
    memToRegT memToReg;
    srcBT     aluSrcB;
    immSelT   immSel;
    aluCtrlT  aluControl;
    logic     regDst, iOrD, pcSrc, aluSrcA;
    logic     irWrite, memWrite, pcWrite, regWrite;
    logic     branchEq, branchNe;

    // Lines of {opcode, funct3, funct7, cycles, funct decode}
    logic [27:0] stimMem [0:stimDepth-1];
    int          numVectors;
    int          watchdogNs;

    // Reference model state and the row it expects
    stateT       modelState;
    aluCtrlT     curFunct;
    memToRegT    expMemToReg;
    srcBT        expSrcB;
    logic [3:0]  expSel;
    logic [5:0]  expEn;
    immSelT      expImm;
    aluOpT       expAluOp;

    multicycleControl i_multicycleControl (
        .clk          (clk),
        .rst          (rst),
        .opCode_i     (opCode),
        .funct3_i     (funct3),
        .funct7_i     (funct7),
        .memToReg_o   (memToReg),
        .regDst_o     (regDst),
        .iOrD_o       (iOrD),
        .pcSrc_o      (pcSrc),
        .aluSrcB_o    (aluSrcB),
        .aluSrcA_o    (aluSrcA),
        .irWrite_o    (irWrite),
        .memWrite_o   (memWrite),
        .pcWrite_o    (pcWrite),
        .regWrite_o   (regWrite),
        .branchEq_o   (branchEq),
        .branchNe_o   (branchNe),
        .immSel_o     (immSel),
        .aluControl_o (aluControl)
    );

    always #(clkPeriodNs / 2) clk = ~clk;

    `include "tbChecks.svh"

    task automatic stopOnError();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first mismatch");
    endtask

    task automatic setRow(input memToRegT m, input logic [3:0] sel, input srcBT b,
                          input logic [5:0] en, input immSelT imm, input aluOpT op);
        expMemToReg = m;
        expSel      = sel;
        expSrcB     = b;
        expEn       = en;
        expImm      = imm;
        expAluOp    = op;
    endtask

    // Control table
    // sel is {regDst, iOrD, pcSrc, aluSrcA}
    // en is {irWrite, memWrite, pcWrite, regWrite, branchEq, branchNe}
    task automatic lookupRow(input stateT s);
        case (s)
            sFetch:        setRow(selAluOut,  4'b0000, srcBFour, 6'b101000, immI, aluOpAdd);
            sDecode:       setRow(selAluOut,  4'b0000, srcBImm,  6'b000000, immB, aluOpAdd);
            sBeq:          setRow(selAluOut,  4'b0011, srcBReg,  6'b000010, immB, aluOpSub);
            sBne:          setRow(selAluOut,  4'b0011, srcBReg,  6'b000001, immB, aluOpSub);
            sJalWriteReg:  setRow(selPc,      4'b1000, srcBImm,  6'b000100, immJ, aluOpAdd);
            sJumpPc:       setRow(selAluOut,  4'b0010, srcBFour, 6'b001000, immJ, aluOpAdd);
            sJalrWriteReg: setRow(selPc,      4'b1001, srcBImm,  6'b000100, immI, aluOpAdd);
            sAuipcExec:    setRow(selAluOut,  4'b0000, srcBImm,  6'b000000, immU, aluOpAdd);
            sAuipcWb:      setRow(selAluOut,  4'b1001, srcBReg,  6'b000100, immU, aluOpAdd);
            sImmExec:      setRow(selAluOut,  4'b0001, srcBImm,  6'b000000, immI, aluOpFunct);
            sAluWb:        setRow(selAluOut,  4'b1001, srcBImm,  6'b000100, immI, aluOpFunct);
            sLoadAdr:      setRow(selAluOut,  4'b0001, srcBImm,  6'b000000, immI, aluOpAdd);
            sLoadRead:     setRow(selAluOut,  4'b0101, srcBImm,  6'b000000, immI, aluOpAdd);
            sLoadWb:       setRow(selMemData, 4'b1101, srcBImm,  6'b000100, immI, aluOpAdd);
            sStoreAdr:     setRow(selAluOut,  4'b0001, srcBImm,  6'b000000, immS, aluOpAdd);
            sStoreWrite:   setRow(selAluOut,  4'b0101, srcBImm,  6'b010000, immS, aluOpAdd);
            sRegExec:      setRow(selAluOut,  4'b0001, srcBReg,  6'b000000, immI, aluOpFunct);
            default:       setRow(selAluOut,  4'b0000, srcBReg,  6'b000000, immI, aluOpAdd);
        endcase
    endtask

    // Where decode goes for one opcode, sDecode means unknown
    function automatic stateT decodeTarget(input opcodeT op, input funct3T f3);
        stateT n;
        n = sDecode;
        if (op == opBranch)
            n = (f3 == f3Beq) ? sBeq : ((f3 == f3Bne) ? sBne : sFetch);
        else if (op == opJal)
            n = sJalWriteReg;
        else if (op == opJalr)
            n = sJalrWriteReg;
        else if (op == opAuipc)
            n = sAuipcExec;
        else if (op == opImm)
            n = sImmExec;
        else if (op == opLoad)
            n = sLoadAdr;
        else if (op == opStore)
            n = sStoreAdr;
        else if (op == opReg)
            n = sRegExec;
        return n;
    endfunction

    function automatic stateT nextState(input stateT s, input opcodeT op, input funct3T f3);
        stateT n;
        case (s)
            sFetch:                      n = sDecode;
            sDecode:                     n = decodeTarget(op, f3);
            sJalWriteReg, sJalrWriteReg: n = sJumpPc;
            sAuipcExec:                  n = sAuipcWb;
            sImmExec, sRegExec:          n = sAluWb;
            sLoadAdr:                    n = sLoadRead;
            sLoadRead:                   n = sLoadWb;
            sStoreAdr:                   n = sStoreWrite;
            default:                     n = sFetch;
        endcase
        return n;
    endfunction

    task automatic loadStimulus();
        $readmemh("stim_vectors.txt", stimMem);
        numVectors = 0;
        // A zero cycle count ends the list
        while (numVectors < stimDepth && stimMem[6'(numVectors)][7:4] != 4'h0)
            numVectors++;
    endtask

    task automatic driveFields(input int idx);
        logic [27:0] line;
        line   = stimMem[6'(idx)];
        opCode = line[26:20];
        funct3 = line[18:16];
        // Only R-type looks at funct7, others get noise
        // I-type carries the alternate code that its add slot must ignore
        if (line[26:20] == opReg)
            funct7 = line[14:8];
        else if (line[26:20] == opImm)
            funct7 = f7Alt;
        else
            funct7 = 7'($urandom);
    endtask

    // Compare all outputs against the model in the current cycle
    task automatic verifyCycle();
        aluCtrlT expAlu;
        string   stateName;
        stateName = modelState.name();
        lookupRow(modelState);
        case (expAluOp)
            aluOpSub:   expAlu = aluSub;
            aluOpFunct: expAlu = curFunct;
            default:    expAlu = aluAdd;
        endcase
        compareSelects(stateName, memToReg, expMemToReg, aluSrcB, expSrcB,
                       {regDst, iOrD, pcSrc, aluSrcA}, expSel);
        compareEnables(stateName, {irWrite, memWrite, pcWrite, regWrite, branchEq, branchNe},
                       expEn);
        compareImmSel(stateName, immSel, expImm);
        compareAluCtrl(stateName, aluControl, expAlu);
    endtask

    initial
    begin
        int vecIdx;
        int cyc;
        int lineCycles;
        bit knownOp;
        bit fieldsPending;
        void'($urandom(8579));
        clk           = 1'b0;
        rst           = 1'b1;
        opCode        = '0;
        funct3        = '0;
        funct7        = '0;
        modelState    = sFetch;
        curFunct      = aluAnd;
        fieldsPending = 1'b0;
        loadStimulus();
        watchdogNs = (numVectors * cyclesPerVector + resetCycles) * clkPeriodNs;

        // First fields go in during the last reset cycle
        repeat (resetCycles - 1) @(negedge clk);
        driveFields(0);
        @(negedge clk);

        for (vecIdx = 0; vecIdx < numVectors; vecIdx++)
        begin
            // Fields held back behind a last decode cycle go in during fetch
            if (fieldsPending)
            begin
                driveFields(vecIdx);
                fieldsPending = 1'b0;
            end
            lineCycles = int'(stimMem[6'(vecIdx)][7:4]);
            curFunct   = aluCtrlT'(stimMem[6'(vecIdx)][2:0]);
            knownOp    = (decodeTarget(opCode, f3Beq) != sDecode);
            for (cyc = 0; cyc < lineCycles; cyc++)
            begin
                // Cycle 0 right after any reset is the fetch row with aluAdd
                verifyCycle();
                if (rst)
                    rst = 1'b0;
                if (cyc == lineCycles - 1)
                begin
                    // Unknown opcode only leaves decode through reset
                    if (!knownOp)
                        rst = 1'b1;
                    if (vecIdx + 1 < numVectors)
                    begin
                        // Decode still reads the fields at the coming edge
                        if (modelState == sDecode && !rst)
                            fieldsPending = 1'b1;
                        else
                            driveFields(vecIdx + 1);
                    end
                end
                modelState = rst ? sFetch : nextState(modelState, opCode, funct3);
                @(negedge clk);
            end
            if (knownOp && modelState != sFetch)
            begin
                $display("stimulus line %0d does not end its instruction after %0d cycles",
                         vecIdx, lineCycles);
                stopOnError();
            end
        end

        // Sequencer back in fetch after the last line
        verifyCycle();
        if (numVectors > 0)
        begin
            $display("%0d instructions checked", numVectors);
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("stimulus file held no instructions");
            stopOnError();
        end
    end

    // Watchdog
    initial
    begin
        wait (watchdogNs > 0);
        #(watchdogNs);
        $display("watchdog timeout, run did not finish within %0d ns", watchdogNs);
        stopOnError();
    end

endmodule

// File: stim_vectors.txt
// Columns opcode_funct3_funct7_cycles_decode, all hex
// cycles counts from fetch, decode is the funct ALU code (0 where unused), cycles 0 ends
// Branches, two with an invalid funct3
63_0_00_3_0
63_1_00_3_0
63_2_00_2_0
63_7_00_2_0
// Jumps and AUIPC
6F_0_00_4_0
67_0_00_4_0
17_0_00_4_0
// Load and store
03_2_00_5_0
23_2_00_4_0
// I-type, all eight funct3 values
13_0_00_4_2
13_1_00_4_7
13_2_00_4_4
13_3_00_4_4
13_4_00_4_6
13_5_00_4_3
13_6_00_4_1
13_7_00_4_0
// R-type, add slot with and without the alternate funct7
33_0_00_4_2
33_0_01_4_5
33_1_01_4_7
33_2_00_4_4
33_3_00_4_4
33_4_00_4_6
33_5_00_4_3
33_6_00_4_1
33_7_00_4_0
// Unknown opcodes held in decode, then reset
7F_0_00_5_0
0B_3_00_2_0
// Back to normal after reset
33_0_01_4_5
03_2_00_5_0
63_1_00_3_0
23_5_00_4_0
// End of list
00_0_00_0_0

// File: compile.f
+incdir+.
isaPkg.sv
ctrlPkg.sv
controlFsm.sv
aluDecoder.sv
multicycleControl.sv
tbMulticycleControl.sv

// File: run.sh
#!/bin/sh
# Build and run the multicycle control testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f compile.f --top-module tbMulticycleControl \
    --Mdir obj_dir -o tbMulticycleControl

# The log carries the verdict
./obj_dir/tbMulticycleControl > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi
echo "simulation passed"
